// File: source/mmu_pkg.sv
package mmu_pkg;

  typedef enum logic [1:0] {
    acc_fetch = 2'd0,
    acc_load  = 2'd1,
    acc_store = 2'd2
  } access_e;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_s = 2'd1,
    priv_m = 2'd3
  } priv_e;

  typedef enum logic [2:0] {
    ws_idle  = 3'd0,
    ws_send  = 3'd1,  // PTE read strobe
    ws_wait  = 3'd2,
    ws_fill  = 3'd3,
    ws_fault = 3'd4
  } walk_state_e;

  localparam int TLB_ENTRIES     = 8;
  localparam int TLB_INDEX_WIDTH = 3;

endpackage

// File: source/mmu_top.sv
`timescale 1ns/100ps

module mmu_top (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             req_v_i,
  input  logic [sv39_pkg::VADDR_WIDTH-1:0] req_vaddr_i,
  input  mmu_pkg::access_e                 req_access_i,
  input  mmu_pkg::priv_e                   priv_mode_i,
  input  logic                             sum_i,
  input  logic                             mxr_i,
  input  logic [sv39_pkg::PPN_WIDTH-1:0]   satp_ppn_i,
  input  logic                             flush_i,
  output logic                             resp_v_o,
  output logic [sv39_pkg::PADDR_WIDTH-1:0] resp_paddr_o,
  output logic                             resp_fault_o,
  output logic                             busy_o,
  output logic                             mem_req_o,
  output logic [sv39_pkg::PADDR_WIDTH-1:0] mem_addr_o,
  input  logic                             mem_resp_v_i,
  input  logic [sv39_pkg::PTE_WIDTH-1:0]   mem_resp_data_i
);
  import sv39_pkg::*;

  logic                 miss_v;
  logic [VPN_WIDTH-1:0] miss_vpn;
  logic                 fill_v;
  logic [VPN_WIDTH-1:0] fill_vpn;
  logic [PPN_WIDTH-1:0] fill_ppn;
  level_e               fill_level;
  logic [5:0]           fill_flags;
  logic                 walk_fault_v;
  logic                 walker_busy;

  tlb u_tlb (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v_i),
    .req_vaddr_i    (req_vaddr_i),
    .req_access_i   (req_access_i),
    .priv_mode_i    (priv_mode_i),
    .sum_i          (sum_i),
    .mxr_i          (mxr_i),
    .flush_i        (flush_i),
    .walker_busy_i  (walker_busy),
    .fill_v_i       (fill_v),
    .fill_vpn_i     (fill_vpn),
    .fill_ppn_i     (fill_ppn),
    .fill_level_i   (fill_level),
    .fill_flags_i   (fill_flags),
    .walk_fault_v_i (walk_fault_v),
    .miss_v_o       (miss_v),
    .miss_vpn_o     (miss_vpn),
    .resp_v_o       (resp_v_o),
    .resp_paddr_o   (resp_paddr_o),
    .resp_fault_o   (resp_fault_o),
    .busy_o         (busy_o)
  );

  page_table_walker u_page_table_walker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_v_i        (miss_v),
    .miss_vpn_i      (miss_vpn),
    .satp_ppn_i      (satp_ppn_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .fill_v_o        (fill_v),
    .fill_vpn_o      (fill_vpn),
    .fill_ppn_o      (fill_ppn),
    .fill_level_o    (fill_level),
    .fill_flags_o    (fill_flags),
    .walk_fault_v_o  (walk_fault_v),
    .busy_o          (walker_busy)
  );

endmodule

// File: source/page_table_walker.sv
`timescale 1ns/100ps

module page_table_walker (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_v_i,
  input  logic [sv39_pkg::VPN_WIDTH-1:0]   miss_vpn_i,
  input  logic [sv39_pkg::PPN_WIDTH-1:0]   satp_ppn_i,
  input  logic                             mem_resp_v_i,
  input  logic [sv39_pkg::PTE_WIDTH-1:0]   mem_resp_data_i,
  output logic                             mem_req_o,
  output logic [sv39_pkg::PADDR_WIDTH-1:0] mem_addr_o,
  output logic                             fill_v_o,
  output logic [sv39_pkg::VPN_WIDTH-1:0]   fill_vpn_o,
  output logic [sv39_pkg::PPN_WIDTH-1:0]   fill_ppn_o,
  output sv39_pkg::level_e                 fill_level_o,
  output logic [5:0]                       fill_flags_o,
  output logic                             walk_fault_v_o,
  output logic                             busy_o
);
  import sv39_pkg::*;
  import mmu_pkg::*;

  walk_state_e state_r;
  walk_state_e state_n;

  logic [1:0]                level_r;
  logic [VPN_WIDTH-1:0]      vpn_r;
  logic [PPN_WIDTH-1:0]      ppn_r;  // Table base during the walk, leaf PPN at fill
  logic [5:0]                flags_r;
  logic [VPN_PART_WIDTH-1:0] vpn_part;

  logic [PTE_WIDTH-1:0] pte_data;
  level_e               walk_level;
  logic                 is_leaf;
  logic                 is_fault;
  logic [PPN_WIDTH-1:0] pte_ppn;
  logic [5:0]           pte_flags;

  logic start;
  logic pte_v;

  assign pte_data   = mem_resp_data_i;
  assign walk_level = level_e'(level_r);
  assign vpn_part   = vpn_r[level_r*VPN_PART_WIDTH +: VPN_PART_WIDTH];
  assign start      = (state_r == ws_idle) & miss_v_i;
  assign pte_v      = (state_r == ws_wait) & mem_resp_v_i;

  pte_decode u_pte_decode (
    .pte_i      (pte_data),
    .level_i    (walk_level),
    .vpn_low_i  (vpn_r[2*VPN_PART_WIDTH-1:0]),
    .is_leaf_o  (is_leaf),
    .is_fault_o (is_fault),
    .ppn_o      (pte_ppn),
    .flags_o    (pte_flags)
  );

  always_comb begin
    state_n = state_r;
    case (state_r)
      ws_idle: begin
        if (miss_v_i) begin
          state_n = ws_send;
        end
      end
      ws_send: state_n = ws_wait;
      ws_wait: begin
        if (mem_resp_v_i) begin
          if (is_fault) begin
            state_n = ws_fault;
          end else if (is_leaf) begin
            state_n = ws_fill;
          end else begin
            state_n = ws_send;  // Next level down
          end
        end
      end
      ws_fill:  state_n = ws_idle;
      ws_fault: state_n = ws_idle;
      default:  state_n = ws_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ws_idle;
      level_r <= '0;
    end else begin
      state_r <= state_n;
      if (start) begin
        level_r <= 2'(LEVELS - 1);
      end else if (pte_v && !is_leaf && !is_fault) begin
        level_r <= level_r - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      vpn_r <= miss_vpn_i;
      ppn_r <= satp_ppn_i;
    end else if (pte_v) begin
      ppn_r <= pte_ppn;
    end
    if (pte_v && is_leaf) begin
      flags_r <= pte_flags;
    end
  end

  assign mem_req_o  = (state_r == ws_send);
  assign mem_addr_o = {ppn_r, vpn_part, {PTE_BYTES_LOG2{1'b0}}};

  assign fill_v_o     = (state_r == ws_fill);
  assign fill_vpn_o   = vpn_r;
  assign fill_ppn_o   = ppn_r;
  assign fill_level_o = walk_level;  // Level does not move on a leaf
  assign fill_flags_o = flags_r;

  assign walk_fault_v_o = (state_r == ws_fault);
  assign busy_o         = (state_r != ws_idle);

endmodule

// File: source/pte_decode.sv
`timescale 1ns/100ps

module pte_decode (
  input  logic [sv39_pkg::PTE_WIDTH-1:0] pte_i,
  input  sv39_pkg::level_e               level_i,
  input  logic [17:0]                    vpn_low_i,
  output logic                           is_leaf_o,
  output logic                           is_fault_o,
  output logic [sv39_pkg::PPN_WIDTH-1:0] ppn_o,
  output logic [5:0]                     flags_o
);
  import sv39_pkg::*;

  logic                 pte_v;
  logic                 pte_r;
  logic                 pte_w;
  logic                 pte_x;
  logic                 leaf;
  logic                 misaligned;
  logic [PPN_WIDTH-1:0] pte_ppn;

  assign pte_v   = pte_i[PTE_V];
  assign pte_r   = pte_i[PTE_R];
  assign pte_w   = pte_i[PTE_W];
  assign pte_x   = pte_i[PTE_X];
  assign pte_ppn = pte_i[PTE_PPN_LSB +: PPN_WIDTH];
  assign leaf    = pte_r | pte_w | pte_x;

  // Superpages take their low PPN parts from the VPN
  always_comb begin
    misaligned = 1'b0;
    ppn_o      = pte_ppn;
    case (level_i)
      lvl_1g: begin
        misaligned = |pte_ppn[2*VPN_PART_WIDTH-1:0];
        if (leaf) begin
          ppn_o = {pte_ppn[PPN_WIDTH-1:2*VPN_PART_WIDTH], vpn_low_i};
        end
      end
      lvl_2m: begin
        misaligned = |pte_ppn[VPN_PART_WIDTH-1:0];
        if (leaf) begin
          ppn_o = {pte_ppn[PPN_WIDTH-1:VPN_PART_WIDTH], vpn_low_i[VPN_PART_WIDTH-1:0]};
        end
      end
      default: begin
        misaligned = 1'b0;
        ppn_o      = pte_ppn;
      end
    endcase
  end

  assign is_leaf_o  = leaf;
  assign is_fault_o = ~pte_v
                    | (pte_w & ~pte_r)                  // Reserved encoding
                    | (~leaf & (level_i == lvl_4k))     // Pointer past the last level
                    | (leaf & misaligned);

  assign flags_o = {pte_r, pte_w, pte_x, pte_i[PTE_U], pte_i[PTE_A], pte_i[PTE_D]};

endmodule

// File: source/sv39_pkg.sv
package sv39_pkg;

  // Address layout
  localparam int VADDR_WIDTH       = 39;
  localparam int PADDR_WIDTH       = 40;
  localparam int PAGE_OFFSET_WIDTH = 12;
  localparam int VPN_WIDTH         = 27;
  localparam int PPN_WIDTH         = 28;  // Low part of the PTE PPN only
  localparam int VPN_PART_WIDTH    = 9;

  // PTE layout
  localparam int PTE_WIDTH      = 64;
  localparam int PTE_BYTES_LOG2 = 3;
  localparam int PTE_V          = 0;
  localparam int PTE_R          = 1;
  localparam int PTE_W          = 2;
  localparam int PTE_X          = 3;
  localparam int PTE_U          = 4;
  localparam int PTE_A          = 6;
  localparam int PTE_D          = 7;
  localparam int PTE_PPN_LSB    = 10;

  localparam int LEVELS = 3;

  // Page size of a leaf, equal to the walk level it was found at
  typedef enum logic [1:0] {
    lvl_4k = 2'd0,
    lvl_2m = 2'd1,
    lvl_1g = 2'd2
  } level_e;

endpackage

// File: source/tlb.sv
`timescale 1ns/100ps

module tlb (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             req_v_i,
  input  logic [sv39_pkg::VADDR_WIDTH-1:0] req_vaddr_i,
  input  mmu_pkg::access_e                 req_access_i,
  input  mmu_pkg::priv_e                   priv_mode_i,
  input  logic                             sum_i,
  input  logic                             mxr_i,
  input  logic                             flush_i,
  input  logic                             walker_busy_i,
  input  logic                             fill_v_i,
  input  logic [sv39_pkg::VPN_WIDTH-1:0]   fill_vpn_i,
  input  logic [sv39_pkg::PPN_WIDTH-1:0]   fill_ppn_i,
  input  sv39_pkg::level_e                 fill_level_i,
  input  logic [5:0]                       fill_flags_i,
  input  logic                             walk_fault_v_i,
  output logic                             miss_v_o,
  output logic [sv39_pkg::VPN_WIDTH-1:0]   miss_vpn_o,
  output logic                             resp_v_o,
  output logic [sv39_pkg::PADDR_WIDTH-1:0] resp_paddr_o,
  output logic                             resp_fault_o,
  output logic                             busy_o
);
  import sv39_pkg::*;
  import mmu_pkg::*;

  logic [VPN_WIDTH-1:0]       ent_vpn_r   [TLB_ENTRIES];
  logic [PPN_WIDTH-1:0]       ent_ppn_r   [TLB_ENTRIES];
  level_e                     ent_level_r [TLB_ENTRIES];
  logic [5:0]                 ent_flags_r [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]     valid_r;
  logic [TLB_INDEX_WIDTH-1:0] rr_r;

  // Request held for lookup and replay
  logic [VADDR_WIDTH-1:0] vaddr_r;
  access_e                access_r;
  priv_e                  priv_r;
  logic                   sum_r;
  logic                   mxr_r;
  logic                   lookup_v_r;
  logic                   pending_r;

  logic                       accept;
  logic                       flush;
  logic [VPN_WIDTH-1:0]       req_vpn;
  logic                       hit;
  logic [TLB_INDEX_WIDTH-1:0] hit_idx;
  logic [PPN_WIDTH-1:0]       phys_ppn;
  level_e                     hit_level;
  logic                       f_r, f_w, f_x, f_u, f_a, f_d;
  logic                       m_mode;
  logic                       priv_fault;
  logic                       acc_fault;
  logic                       ad_fault;

  function automatic logic [VPN_WIDTH-1:0] vpn_mask(level_e lvl);
    case (lvl)
      lvl_1g:  vpn_mask = {{VPN_PART_WIDTH{1'b1}}, {2*VPN_PART_WIDTH{1'b0}}};
      lvl_2m:  vpn_mask = {{2*VPN_PART_WIDTH{1'b1}}, {VPN_PART_WIDTH{1'b0}}};
      default: vpn_mask = '1;
    endcase
  endfunction

  assign busy_o  = lookup_v_r | pending_r | walker_busy_i;
  assign accept  = req_v_i & ~busy_o;
  assign flush   = flush_i & ~busy_o;
  assign req_vpn = vaddr_r[PAGE_OFFSET_WIDTH +: VPN_WIDTH];
  assign m_mode  = (priv_r == priv_m);

  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_r[i] && ((ent_vpn_r[i] ^ req_vpn) & vpn_mask(ent_level_r[i])) == '0) begin
        hit     = 1'b1;
        hit_idx = TLB_INDEX_WIDTH'(i);
      end
    end
  end

  assign hit_level                    = ent_level_r[hit_idx];
  assign {f_r, f_w, f_x, f_u, f_a, f_d} = ent_flags_r[hit_idx];

  always_comb begin
    case (hit_level)
      lvl_1g:  phys_ppn = {ent_ppn_r[hit_idx][PPN_WIDTH-1:2*VPN_PART_WIDTH],
                           req_vpn[2*VPN_PART_WIDTH-1:0]};
      lvl_2m:  phys_ppn = {ent_ppn_r[hit_idx][PPN_WIDTH-1:VPN_PART_WIDTH],
                           req_vpn[VPN_PART_WIDTH-1:0]};
      default: phys_ppn = ent_ppn_r[hit_idx];
    endcase
  end

  assign priv_fault = (f_u & (priv_r == priv_s) & (~sum_r | (access_r == acc_fetch)))
                    | (~f_u & (priv_r == priv_u));
  assign acc_fault  = ((access_r == acc_fetch) & ~f_x)
                    | ((access_r == acc_load) & ~(f_r | (f_x & mxr_r)))
                    | ((access_r == acc_store) & ~f_w);
  assign ad_fault   = ~f_a | ((access_r == acc_store) & ~f_d);

  assign miss_v_o     = lookup_v_r & ~m_mode & ~hit;
  assign miss_vpn_o   = req_vpn;
  assign resp_v_o     = (lookup_v_r & (m_mode | hit)) | walk_fault_v_i;
  assign resp_fault_o = walk_fault_v_i
                      | (lookup_v_r & ~m_mode & hit & (priv_fault | acc_fault | ad_fault));
  assign resp_paddr_o = m_mode ? PADDR_WIDTH'(vaddr_r)
                               : {phys_ppn, vaddr_r[PAGE_OFFSET_WIDTH-1:0]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_v_r <= 1'b0;
      pending_r  <= 1'b0;
      valid_r    <= '0;
      rr_r       <= '0;
    end else begin
      lookup_v_r <= accept | fill_v_i;  // A fill replays the held request
      if (miss_v_o) begin
        pending_r <= 1'b1;
      end else if (fill_v_i || walk_fault_v_i) begin
        pending_r <= 1'b0;
      end
      if (flush) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[rr_r] <= 1'b1;
        rr_r          <= rr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vaddr_r  <= req_vaddr_i;
      access_r <= req_access_i;
      priv_r   <= priv_mode_i;
      sum_r    <= sum_i;
      mxr_r    <= mxr_i;
    end
    if (fill_v_i) begin
      ent_vpn_r[rr_r]   <= fill_vpn_i;
      ent_ppn_r[rr_r]   <= fill_ppn_i;
      ent_level_r[rr_r] <= fill_level_i;
      ent_flags_r[rr_r] <= fill_flags_i;
    end
  end

endmodule

// File: tb.f
source/sv39_pkg.sv
source/mmu_pkg.sv
source/pte_decode.sv
source/page_table_walker.sv
source/tlb.sv
source/mmu_top.sv
tb/mmu_chk.sv
tb/mmu_tb.sv

// File: tb/mmu_chk.sv
`timescale 1ns/100ps

module mmu_chk (
  input logic clk_i,
  input logic reset_i,
  input logic req_v_i,
  input logic resp_v_i,
  input logic mem_req_i,
  input logic busy_i
);

  int assert_fails = 0;  // Failed assertion count

  // Responses are single-cycle strobes
  resp_single_cycle: assert property (
    @(posedge clk_i) disable iff (reset_i) resp_v_i |=> !resp_v_i
  ) else begin
    $error("resp_v_o stayed high for two cycles");
    assert_fails++;
  end

  mem_req_while_busy: assert property (
    @(posedge clk_i) disable iff (reset_i) mem_req_i |-> busy_i
  ) else begin
    $error("mem_req_o raised while busy_o was low");
    assert_fails++;
  end

  quiet_after_reset: assert property (
    @(posedge clk_i) reset_i |=> (!resp_v_i && !mem_req_i && !busy_i)
  ) else begin
    $error("Outputs not idle after reset");
    assert_fails++;
  end

  // A walk step ends in another PTE read or in the response
  mem_req_answered: assert property (
    @(posedge clk_i) disable iff (reset_i)
      mem_req_i |=> (!req_v_i until (resp_v_i || mem_req_i))
  ) else begin
    $error("New request strobe before the memory request was answered");
    assert_fails++;
  end

endmodule

bind mmu_top mmu_chk u_mmu_chk (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .req_v_i   (req_v_i),
  .resp_v_i  (resp_v_o),
  .mem_req_i (mem_req_o),
  .busy_i    (busy_o)
);

// File: tb/mmu_tb.sv
`timescale 1ns/100ps

module mmu_tb;
  import sv39_pkg::*;
  import mmu_pkg::*;

  localparam int TIMEOUT = 200;
  localparam logic [PPN_WIDTH-1:0] ROOT_PPN = 28'h0000100;
  localparam logic [PPN_WIDTH-1:0] L1_PPN   = 28'h0000101;
  localparam logic [PPN_WIDTH-1:0] L0_PPN   = 28'h0000102;
  localparam logic [7:0] FV = 8'(1 << PTE_V);
  localparam logic [7:0] FR = 8'(1 << PTE_R);
  localparam logic [7:0] FW = 8'(1 << PTE_W);
  localparam logic [7:0] FX = 8'(1 << PTE_X);
  localparam logic [7:0] FU = 8'(1 << PTE_U);
  localparam logic [7:0] FA = 8'(1 << PTE_A);
  localparam logic [7:0] FD = 8'(1 << PTE_D);

  logic                   clk_i;
  logic                   reset_i;
  logic                   req_v_i;
  logic [VADDR_WIDTH-1:0] req_vaddr_i;
  access_e                req_access_i;
  priv_e                  priv_mode_i;
  logic                   sum_i;
  logic                   mxr_i;
  logic [PPN_WIDTH-1:0]   satp_ppn_i;
  logic                   flush_i;
  logic                   resp_v_o;
  logic [PADDR_WIDTH-1:0] resp_paddr_o;
  logic                   resp_fault_o;
  logic                   busy_o;
  logic                   mem_req_o;
  logic [PADDR_WIDTH-1:0] mem_addr_o;
  logic                   mem_resp_v_i;
  logic [PTE_WIDTH-1:0]   mem_resp_data_i;

  logic [PTE_WIDTH-1:0]   ptes [logic [PADDR_WIDTH-1:0]];  // Page-table memory
  int                     mem_reads = 0;
  logic [PADDR_WIDTH-1:0] got_paddr;
  logic                   got_fault;
  int                     got_cycles;
  int                     got_reads;

  mmu_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Answers each PTE read after 1 to 4 cycles
  initial begin : mem_model
    int                     delay;
    logic [PADDR_WIDTH-1:0] addr;
    void'($urandom(32'hfd68));
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    forever begin
      @(negedge clk_i);
      mem_resp_v_i = 1'b0;
      if (mem_req_o) begin
        addr = mem_addr_o;
        mem_reads++;
        delay = 1 + ($urandom % 4);
        repeat (delay) @(negedge clk_i);
        mem_resp_v_i    = 1'b1;
        mem_resp_data_i = ptes.exists(addr) ? ptes[addr] : '0;  // Missing PTE reads as invalid
      end
    end
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  // Stop as soon as a bound assertion has failed
  always @(negedge clk_i) begin
    if (DUT.u_mmu_chk.assert_fails != 0) begin
      $display("A bound assertion failed");
      abort_run();
    end
  end

  task automatic check_paddr(input string name, input logic [PADDR_WIDTH-1:0] got,
                             input logic [PADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s: resp_paddr_o got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_fault(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: resp_fault_o got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name, input string what, input int got,
                               input int exp);
    if (got != exp) begin
      $display("Fail %s: %s got 0x%0h, expected 0x%0h", name, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [PTE_WIDTH-1:0] make_pte(logic [PPN_WIDTH-1:0] ppn, logic [7:0] flags);
    return (PTE_WIDTH'(ppn) << PTE_PPN_LSB) | PTE_WIDTH'(flags);
  endfunction

  function automatic logic [PPN_WIDTH-1:0] table_of(int lvl);
    case (lvl)
      2:       return ROOT_PPN;
      1:       return L1_PPN;
      default: return L0_PPN;
    endcase
  endfunction

  function automatic logic [PADDR_WIDTH-1:0] pte_addr(logic [VADDR_WIDTH-1:0] va, int lvl);
    return {table_of(lvl), va[PAGE_OFFSET_WIDTH + lvl*VPN_PART_WIDTH +: VPN_PART_WIDTH], 3'b000};
  endfunction

  // Pointer PTEs down to leaf_lvl, then the given PTE there
  function automatic void build_walk(logic [VADDR_WIDTH-1:0] va, int leaf_lvl,
                                     logic [PTE_WIDTH-1:0] leaf_pte);
    ptes.delete();
    for (int lvl = LEVELS - 1; lvl > leaf_lvl; lvl--) begin
      ptes[pte_addr(va, lvl)] = make_pte(table_of(lvl - 1), FV);
    end
    ptes[pte_addr(va, leaf_lvl)] = leaf_pte;
  endfunction

  function automatic logic [PADDR_WIDTH-1:0] expected_paddr(logic [VADDR_WIDTH-1:0] va,
                                                            logic [PPN_WIDTH-1:0] ppn, int lvl);
    logic [PADDR_WIDTH-1:0] offset_mask;
    offset_mask = (PADDR_WIDTH'(1) << (PAGE_OFFSET_WIDTH + lvl*VPN_PART_WIDTH)) - 1;
    return ((PADDR_WIDTH'(ppn) << PAGE_OFFSET_WIDTH) & ~offset_mask)
         | (PADDR_WIDTH'(va) & offset_mask);
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk_i);
    while (busy_o) begin
      if (n >= TIMEOUT) begin
        $display("Timed out waiting for busy_o to drop");
        abort_run();
      end
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic flush_tlb();
    wait_idle();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  task automatic translate(input logic [VADDR_WIDTH-1:0] va, input access_e acc, input priv_e priv,
                           input logic sum, input logic mxr);
    int start_reads;
    wait_idle();
    start_reads  = mem_reads;
    req_v_i      = 1'b1;
    req_vaddr_i  = va;
    req_access_i = acc;
    priv_mode_i  = priv;
    sum_i        = sum;
    mxr_i        = mxr;
    @(negedge clk_i);
    req_v_i    = 1'b0;
    got_cycles = 1;
    while (!resp_v_o) begin
      if (got_cycles >= TIMEOUT) begin
        $display("Timed out waiting for resp_v_o");
        abort_run();
      end
      @(negedge clk_i);
      got_cycles++;
    end
    got_paddr = resp_paddr_o;
    got_fault = resp_fault_o;
    got_reads = mem_reads - start_reads;
  endtask

  task automatic walk_and_hit_4k();
    logic [VADDR_WIDTH-1:0] va;
    va = 39'h40_2468_1abc;
    flush_tlb();
    build_walk(va, 0, make_pte(28'h00abcd, FV | FR | FW | FA | FD));
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("4k walk", got_fault, 1'b0);
    check_paddr("4k walk", got_paddr, expected_paddr(va, 28'h00abcd, 0));
    compare_count("4k walk", "PTE reads", got_reads, 3);
    translate(va + 39'h10, acc_store, priv_s, 1'b0, 1'b0);  // Same page hits
    check_fault("4k hit", got_fault, 1'b0);
    check_paddr("4k hit", got_paddr, expected_paddr(va + 39'h10, 28'h00abcd, 0));
    compare_count("4k hit", "PTE reads", got_reads, 0);
    compare_count("4k hit", "latency", got_cycles, 1);
  endtask

  task automatic translate_superpages();
    logic [VADDR_WIDTH-1:0] va;
    va = 39'h15_5abc_d123;
    flush_tlb();
    build_walk(va, 1, make_pte(28'h0123400, FV | FR | FA));
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("2M leaf", got_fault, 1'b0);
    check_paddr("2M leaf", got_paddr, expected_paddr(va, 28'h0123400, 1));
    compare_count("2M leaf", "PTE reads", got_reads, 2);
    flush_tlb();
    build_walk(va, 2, make_pte(28'h0c40000, FV | FX | FA));
    translate(va, acc_fetch, priv_s, 1'b0, 1'b0);
    check_fault("1G leaf", got_fault, 1'b0);
    check_paddr("1G leaf", got_paddr, expected_paddr(va, 28'h0c40000, 2));
    compare_count("1G leaf", "PTE reads", got_reads, 1);
    flush_tlb();
    build_walk(va, 1, make_pte(28'h0123401, FV | FR | FA));
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("misaligned 2M", got_fault, 1'b1);
  endtask

  task automatic fault_bad_ptes();
    logic [VADDR_WIDTH-1:0] va;
    va = 39'h2a_1357_9000;
    flush_tlb();
    build_walk(va, 2, '0);
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("V clear", got_fault, 1'b1);
    compare_count("V clear", "PTE reads", got_reads, 1);
    // A store to this page would pass the permission check
    build_walk(va, 1, make_pte(28'h0000200, FV | FW | FA | FD));
    translate(va, acc_store, priv_s, 1'b0, 1'b0);
    check_fault("W without R", got_fault, 1'b1);
    build_walk(va, 0, make_pte(28'h0000300, FV));
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("pointer at level 0", got_fault, 1'b1);
    compare_count("pointer at level 0", "PTE reads", got_reads, 3);
  endtask

  task automatic perm_case(input string name, input logic [7:0] flags, input access_e acc,
                           input priv_e priv, input logic sum, input logic mxr,
                           input logic exp_fault);
    logic [VADDR_WIDTH-1:0] va;
    va = 39'h31_8642_0f08;
    flush_tlb();
    build_walk(va, 0, make_pte(28'h0055aa0, flags));
    translate(va, acc, priv, sum, mxr);
    check_fault(name, got_fault, exp_fault);
    if (!exp_fault) begin
      check_paddr(name, got_paddr, expected_paddr(va, 28'h0055aa0, 0));
    end
  endtask

  task automatic apply_permission_rules();
    perm_case("U page, S mode, SUM clear", FV | FR | FU | FA, acc_load, priv_s, 1'b0, 1'b0, 1'b1);
    translate(39'h31_8642_0f08, acc_load, priv_s, 1'b1, 1'b0);  // Entry stays after the fault
    check_fault("U page, S mode, SUM set", got_fault, 1'b0);
    compare_count("U page, S mode, SUM set", "PTE reads", got_reads, 0);
    perm_case("S page, U mode", FV | FR | FA, acc_load, priv_u, 1'b0, 1'b0, 1'b1);
    perm_case("U page, U mode", FV | FR | FU | FA, acc_load, priv_u, 1'b0, 1'b0, 1'b0);
    perm_case("store without W", FV | FR | FA | FD, acc_store, priv_s, 1'b0, 1'b0, 1'b1);
    perm_case("store without D", FV | FR | FW | FA, acc_store, priv_s, 1'b0, 1'b0, 1'b1);
    perm_case("load X-only", FV | FX | FA, acc_load, priv_s, 1'b0, 1'b0, 1'b1);
    perm_case("load X-only, MXR", FV | FX | FA, acc_load, priv_s, 1'b0, 1'b1, 1'b0);
    perm_case("fetch without X", FV | FR | FA, acc_fetch, priv_s, 1'b0, 1'b0, 1'b1);
    perm_case("A clear", FV | FR, acc_load, priv_s, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic bypass_and_flush();
    logic [VADDR_WIDTH-1:0] va;
    va = 39'h7f_0123_4567;
    translate(va, acc_store, priv_m, 1'b0, 1'b0);
    check_fault("M mode", got_fault, 1'b0);
    check_paddr("M mode", got_paddr, {1'b0, va});
    compare_count("M mode", "latency", got_cycles, 1);
    compare_count("M mode", "PTE reads", got_reads, 0);
    va = 39'h0c_0ffe_e123;
    flush_tlb();
    build_walk(va, 0, make_pte(28'h0777000, FV | FR | FW | FA | FD));
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    compare_count("before flush", "PTE reads", got_reads, 3);
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    compare_count("repeat before flush", "PTE reads", got_reads, 0);
    flush_tlb();
    translate(va, acc_load, priv_s, 1'b0, 1'b0);
    check_fault("after flush", got_fault, 1'b0);
    check_paddr("after flush", got_paddr, expected_paddr(va, 28'h0777000, 0));
    compare_count("after flush", "PTE reads", got_reads, 3);
  endtask

  initial begin
    reset_i      = 1'b1;
    req_v_i      = 1'b0;
    req_vaddr_i  = '0;
    req_access_i = acc_load;
    priv_mode_i  = priv_s;
    sum_i        = 1'b0;
    mxr_i        = 1'b0;
    satp_ppn_i   = ROOT_PPN;
    flush_i      = 1'b0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    walk_and_hit_4k();
    translate_superpages();
    fault_bad_ptes();
    apply_permission_rules();
    bypass_and_flush();
    if (DUT.u_mmu_chk.assert_fails != 0) begin
      $display("A bound assertion failed");
      abort_run();
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule
